// ==== flow_pkg.sv ====
// shared types for the flow control path; rv32 only and code values must match the pipeline regs
package flow_pkg;

    // ------------------------------------------------------------------
    // machine word
    // ------------------------------------------------------------------
    localparam int CPU_WIDTH = 32;

    typedef logic [CPU_WIDTH-1:0] cpu_word_t;   // pc, imm, register data

    localparam cpu_word_t PC_STEP = 32'd4;      // sequential fetch step

    // ------------------------------------------------------------------
    // stage commands
    // ------------------------------------------------------------------
    typedef logic [1:0] flow_t;

    localparam flow_t FLOW_WORK    = 2'd0;      // stage advances
    localparam flow_t FLOW_STOP    = 2'd1;      // stage keeps its contents
    localparam flow_t FLOW_REFRESH = 2'd2;      // stage becomes a bubble

    // ------------------------------------------------------------------
    // branch type from decode where zero means no branch
    // ------------------------------------------------------------------
    typedef logic [2:0] branch_t;

    localparam branch_t BRANCH_NONE = 3'd0;
    localparam branch_t BRANCH_BEQ  = 3'd1;
    localparam branch_t BRANCH_BNE  = 3'd2;
    localparam branch_t BRANCH_BLT  = 3'd3;
    localparam branch_t BRANCH_BGE  = 3'd4;
    localparam branch_t BRANCH_BLTU = 3'd5;
    localparam branch_t BRANCH_BGEU = 3'd6;

    // jump type from decode where zero means no jump
    typedef logic [1:0] jump_t;

    localparam jump_t JUMP_NONE  = 2'd0;
    localparam jump_t JUMP_JAL   = 2'd1;
    localparam jump_t JUMP_JALR  = 2'd2;
    localparam jump_t JUMP_FENCE = 2'd3;   // refetch the next instruction

endpackage

// ==== branch_cmp.sv ====
// purely combinational; bltu and bgeu compare unsigned and every other type compares signed
`timescale 1ns/1ns

module branch_cmp
    import flow_pkg::*;
(
    input  branch_t   branch_i,       // branch type in execute
    input  cpu_word_t rs1_data_i,
    input  cpu_word_t rs2_data_i,
    output logic      zero_o,         // operands equal
    output logic      less_o,         // rs1 < rs2
    output logic      more_zero_o     // rs1 >= rs2
);

    logic use_unsigned;
    logic less_s;
    logic less_u;

    // bltu and bgeu are the only unsigned forms
    assign use_unsigned = (branch_i == BRANCH_BLTU) || (branch_i == BRANCH_BGEU);

    assign less_s = $signed(rs1_data_i) < $signed(rs2_data_i);
    assign less_u = rs1_data_i < rs2_data_i;

    assign zero_o      = (rs1_data_i == rs2_data_i);
    assign less_o      = use_unsigned ? less_u : less_s;
    assign more_zero_o = ~less_o;   // ge is just not lt

endmodule

// ==== flow_ctrl.sv ====
// combinational stall/flush priority; next_pc_o is zero whenever no redirect is taken
`timescale 1ns/1ns

module flow_ctrl
    import flow_pkg::*;
(
    input  branch_t   branch_i,             // branch type in execute
    input  jump_t     jump_i,               // jump type in execute
    input  cpu_word_t pc_adder_i,           // pc of the instruction in execute
    input  cpu_word_t imm_i,
    input  cpu_word_t reg1_rd_data_i,       // rs1 for jalr only
    input  logic      zero_i,
    input  logic      more_zero_i,
    input  logic      less_i,
    input  logic      bus_wait_i,           // fetch bus not ready
    input  logic      alu_busy_i,           // multi-cycle alu op running
    input  logic      access_mem_hold_i,    // memory stage waiting
    input  logic      pr_access_mem_flag_i, // load-use on previous access
    input  logic      client_hold_flag_i,
    input  cpu_word_t client_int_addr_i,
    input  logic      client_int_assert_i,
    output cpu_word_t next_pc_o,
    output logic      next_pc_four_o,
    output flow_t     flow_pc_o,
    output flow_t     flow_de_o,
    output flow_t     flow_ex_o,
    output flow_t     flow_as_o,
    output flow_t     flow_wb_o
);

    logic br_taken;   // condition of the branch in execute

    // ------------------------------------------------------------------
    // branch condition
    // ------------------------------------------------------------------
    always_comb begin
        case (branch_i)
            BRANCH_BEQ:  br_taken = zero_i;
            BRANCH_BNE:  br_taken = ~zero_i;
            BRANCH_BLT,
            BRANCH_BLTU: br_taken = less_i;       // sign handled in comparator
            BRANCH_BGE,
            BRANCH_BGEU: br_taken = more_zero_i;
            default:     br_taken = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // priority chain, first match wins
    // ------------------------------------------------------------------
    always_comb begin
        next_pc_o      = '0;
        next_pc_four_o = 1'b0;
        flow_pc_o      = FLOW_WORK;
        flow_de_o      = FLOW_WORK;
        flow_ex_o      = FLOW_WORK;
        flow_as_o      = FLOW_WORK;
        flow_wb_o      = FLOW_WORK;

        if (client_hold_flag_i) begin
            if (client_int_assert_i) begin
                // interrupt entry drops everything in flight
                next_pc_o = client_int_addr_i;
                flow_de_o = FLOW_REFRESH;
                flow_ex_o = FLOW_REFRESH;
                flow_as_o = FLOW_REFRESH;
                flow_wb_o = FLOW_REFRESH;
            end else begin
                flow_pc_o = FLOW_STOP;   // debugger freeze
                flow_de_o = FLOW_STOP;
                flow_ex_o = FLOW_STOP;
                flow_as_o = FLOW_STOP;
                flow_wb_o = FLOW_STOP;
            end
        end else if (access_mem_hold_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_STOP;
            flow_wb_o = FLOW_REFRESH;   // nothing retires this cycle
        end else if (pr_access_mem_flag_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_REFRESH;   // bubble behind the load
        end else if (alu_busy_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_REFRESH;
        end else if (bus_wait_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_REFRESH;   // no instruction fetched
        end else if (branch_i != BRANCH_NONE) begin
            if (br_taken) begin
                next_pc_o = pc_adder_i + imm_i;
                flow_de_o = FLOW_REFRESH;   // squash wrong-path fetches
                flow_ex_o = FLOW_REFRESH;
            end else begin
                next_pc_four_o = 1'b1;
            end
        end else if (jump_i != JUMP_NONE) begin
            flow_de_o = FLOW_REFRESH;
            flow_ex_o = FLOW_REFRESH;
            case (jump_i)
                JUMP_JAL:   next_pc_o = pc_adder_i + imm_i;
                JUMP_JALR:  next_pc_o = reg1_rd_data_i + imm_i;
                JUMP_FENCE: next_pc_o = pc_adder_i + PC_STEP;
                default:    next_pc_o = '0;
            endcase
        end else begin
            next_pc_four_o = 1'b1;   // plain sequential fetch
        end
    end

endmodule

// ==== pc_reg.sv ====
// fetch address register; stop has priority over step, and a redirect loads next_pc_i as is
`timescale 1ns/1ns

module pc_reg
    import flow_pkg::*;
#(
    parameter cpu_word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  flow_t     flow_pc_i,        // command for the fetch stage
    input  logic      next_pc_four_i,   // sequential step
    input  cpu_word_t next_pc_i,        // redirect target
    output cpu_word_t pc_o
);

    cpu_word_t pc_q;

    // ------------------------------------------------------------------
    // pc update
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (flow_pc_i == FLOW_STOP) begin
            pc_q <= pc_q;                 // fetch stalled
        end else if (next_pc_four_i) begin
            pc_q <= pc_q + PC_STEP;
        end else begin
            // branch, jump or interrupt entry
            pc_q <= next_pc_i;
        end
    end

    assign pc_o = pc_q;

endmodule

// ==== stage_valid.sv ====
// one valid bit per stage after fetch; a fetch counts as valid only in a cycle where flow_pc is work
`timescale 1ns/1ns

module stage_valid
    import flow_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  flow_t flow_pc_i,
    input  flow_t flow_de_i,
    input  flow_t flow_ex_i,
    input  flow_t flow_as_i,
    input  flow_t flow_wb_i,
    output logic  valid_de_o,
    output logic  valid_ex_o,
    output logic  valid_as_o,
    output logic  valid_wb_o
);

    logic fetch_valid;
    logic de_q;
    logic ex_q;
    logic as_q;
    logic wb_q;

    // next valid of one stage from its code, own bit and upstream bit
    function automatic logic step_valid(flow_t code, logic own, logic upstream);
        case (code)
            FLOW_WORK:    return upstream;
            FLOW_REFRESH: return 1'b0;      // bubble
            default:      return own;       // stop
        endcase
    endfunction

    assign fetch_valid = (flow_pc_i == FLOW_WORK);

    // ------------------------------------------------------------------
    // valid token chain de -> ex -> as -> wb
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            de_q <= 1'b0;
            ex_q <= 1'b0;
            as_q <= 1'b0;
            wb_q <= 1'b0;
        end else begin
            de_q <= step_valid(flow_de_i, de_q, fetch_valid);
            ex_q <= step_valid(flow_ex_i, ex_q, de_q);
            as_q <= step_valid(flow_as_i, as_q, ex_q);
            wb_q <= step_valid(flow_wb_i, wb_q, as_q);
        end
    end

    assign valid_de_o = de_q;
    assign valid_ex_o = ex_q;
    assign valid_as_o = as_q;
    assign valid_wb_o = wb_q;

endmodule

// ==== flow_top.sv ====
// flow codes are combinational from the inputs; pc and valid bits update one edge later
`timescale 1ns/1ns

module flow_top
    import flow_pkg::*;
#(
    parameter cpu_word_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk_i,
    input  logic      reset_i,
    input  branch_t   branch_i,
    input  jump_t     jump_i,
    input  cpu_word_t pc_adder_i,
    input  cpu_word_t imm_i,
    input  cpu_word_t rs1_data_i,
    input  cpu_word_t rs2_data_i,
    input  logic      bus_wait_i,
    input  logic      alu_busy_i,
    input  logic      access_mem_hold_i,
    input  logic      pr_access_mem_flag_i,
    input  logic      client_hold_flag_i,
    input  cpu_word_t client_int_addr_i,
    input  logic      client_int_assert_i,
    output cpu_word_t pc_o,
    output flow_t     flow_pc_o,
    output flow_t     flow_de_o,
    output flow_t     flow_ex_o,
    output flow_t     flow_as_o,
    output flow_t     flow_wb_o,
    output logic      valid_de_o,
    output logic      valid_ex_o,
    output logic      valid_as_o,
    output logic      valid_wb_o
);

    logic      zero;
    logic      less;
    logic      more_zero;
    cpu_word_t next_pc;
    logic      next_pc_four;

    branch_cmp u_branch_cmp (
        .branch_i    (branch_i),
        .rs1_data_i  (rs1_data_i),
        .rs2_data_i  (rs2_data_i),
        .zero_o      (zero),
        .less_o      (less),
        .more_zero_o (more_zero)
    );

    flow_ctrl u_flow_ctrl (
        .branch_i             (branch_i),
        .jump_i               (jump_i),
        .pc_adder_i           (pc_adder_i),
        .imm_i                (imm_i),
        .reg1_rd_data_i       (rs1_data_i),   // jalr base
        .zero_i               (zero),
        .more_zero_i          (more_zero),
        .less_i               (less),
        .bus_wait_i           (bus_wait_i),
        .alu_busy_i           (alu_busy_i),
        .access_mem_hold_i    (access_mem_hold_i),
        .pr_access_mem_flag_i (pr_access_mem_flag_i),
        .client_hold_flag_i   (client_hold_flag_i),
        .client_int_addr_i    (client_int_addr_i),
        .client_int_assert_i  (client_int_assert_i),
        .next_pc_o            (next_pc),
        .next_pc_four_o       (next_pc_four),
        .flow_pc_o            (flow_pc_o),
        .flow_de_o            (flow_de_o),
        .flow_ex_o            (flow_ex_o),
        .flow_as_o            (flow_as_o),
        .flow_wb_o            (flow_wb_o)
    );

    pc_reg #(
        .RESET_PC (RESET_PC)
    ) u_pc_reg (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .flow_pc_i      (flow_pc_o),
        .next_pc_four_i (next_pc_four),
        .next_pc_i      (next_pc),
        .pc_o           (pc_o)
    );

    stage_valid u_stage_valid (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .flow_pc_i  (flow_pc_o),
        .flow_de_i  (flow_de_o),
        .flow_ex_i  (flow_ex_o),
        .flow_as_i  (flow_as_o),
        .flow_wb_i  (flow_wb_o),
        .valid_de_o (valid_de_o),
        .valid_ex_o (valid_ex_o),
        .valid_as_o (valid_as_o),
        .valid_wb_o (valid_wb_o)
    );

endmodule

// ==== flow_tb_sva.sv ====
// bound into flow_top; checks sample on the rising edge and assume a synchronous reset
`timescale 1ns/1ns

module flow_tb_sva
    import flow_pkg::*;
(
    input logic      clk_i,
    input logic      reset_i,
    input logic      hold_i,        // client hold
    input logic      int_i,         // client interrupt
    input cpu_word_t pc_i,
    input flow_t     flow_pc_i,
    input flow_t     flow_de_i,
    input flow_t     flow_ex_i,
    input flow_t     flow_as_i,
    input flow_t     flow_wb_i,
    input logic [3:0] valid_i       // wb, as, ex, de
);

    // ------------------------------------------------------------------
    // properties
    // ------------------------------------------------------------------
    valid_clear_after_reset: assert property (@(posedge clk_i) reset_i |=> valid_i == 4'b0)
        else $error("valid bits not cleared after reset");

    pc_stable_on_stop: assert property (@(posedge clk_i) disable iff (reset_i)
        flow_pc_i == FLOW_STOP |=> $stable(pc_i))
        else $error("pc moved after a stop cycle");

    client_freeze_all: assert property (@(posedge clk_i) disable iff (reset_i)
        hold_i && !int_i |->
            {flow_pc_i, flow_de_i, flow_ex_i, flow_as_i, flow_wb_i} == {5{FLOW_STOP}})
        else $error("client hold did not stop every stage");

endmodule

bind flow_top flow_tb_sva u_sva (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .hold_i    (client_hold_flag_i),
    .int_i     (client_int_assert_i),
    .pc_i      (pc_o),
    .flow_pc_i (flow_pc_o),
    .flow_de_i (flow_de_o),
    .flow_ex_i (flow_ex_o),
    .flow_as_i (flow_as_o),
    .flow_wb_i (flow_wb_o),
    .valid_i   ({valid_wb_o, valid_as_o, valid_ex_o, valid_de_o})
);

// ==== flow_tb.sv ====
// inputs change on the falling edge; pc and valid bits are checked one edge after the codes
`timescale 1ns/1ns

module flow_tb
    import flow_pkg::*;
();

    localparam cpu_word_t TB_RESET_PC = 32'h0000_1000;
    localparam logic [1:0] OP_RAND = 2'd0;   // operand shaping for branch rows
    localparam logic [1:0] OP_EQ   = 2'd1;
    localparam logic [1:0] OP_LESS = 2'd2;
    localparam logic [1:0] OP_MORE = 2'd3;

    logic clk_i, reset_i, bus_wait_i, alu_busy_i, access_mem_hold_i;
    logic pr_access_mem_flag_i, client_hold_flag_i, client_int_assert_i;
    branch_t branch_i;
    jump_t jump_i;
    cpu_word_t pc_adder_i, imm_i, rs1_data_i, rs2_data_i, client_int_addr_i, pc_o;
    flow_t flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o;
    logic valid_de_o, valid_ex_o, valid_as_o, valid_wb_o;

    // table columns; hold = {client_hold, int_assert, access_hold, pr_access, alu_busy, bus_wait}
    string tab_name[$];
    logic [5:0] tab_hold[$];
    logic [1:0] tab_mode[$];
    branch_t tab_br[$];
    jump_t tab_jp[$];

    logic [31:0] lfsr_state = 32'hd155;
    cpu_word_t m_pc;           // reference model state
    logic [3:0] m_valid;       // [0] de .. [3] wb
    logic [9:0] exp_codes;     // {pc, de, ex, as, wb}
    int flow_errs = 0;
    int pc_errs = 0;
    int valid_errs = 0;
    int cyc;

    flow_top #(.RESET_PC(TB_RESET_PC)) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic cpu_word_t rand_word();
        cpu_word_t w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic [9:0] pack5(flow_t p, flow_t d, flow_t e, flow_t a, flow_t w);
        return {p, d, e, a, w};
    endfunction

    task automatic add_row(string name, logic [5:0] hold, logic [1:0] mode, branch_t br, jump_t jp);
        tab_name.push_back(name);
        tab_hold.push_back(hold);
        tab_mode.push_back(mode);
        tab_br.push_back(br);
        tab_jp.push_back(jp);
    endtask

    // ------------------------------------------------------------------
    // drive one row with operands from the lfsr
    // ------------------------------------------------------------------
    task automatic drive_row(int idx);
        cpu_word_t a, b, t;
        logic uns, a_lt;
        a = rand_word();
        b = rand_word();
        b[31] = ~a[31];   // opposite signs so signed and unsigned order differ
        uns = (tab_br[idx] == BRANCH_BLTU) || (tab_br[idx] == BRANCH_BGEU);
        a_lt = uns ? (a < b) : ($signed(a) < $signed(b));
        if (tab_mode[idx] == OP_EQ) b = a;   // force equality
        if ((tab_mode[idx] == OP_LESS && !a_lt) || (tab_mode[idx] == OP_MORE && a_lt)) begin
            t = a;
            a = b;
            b = t;
        end
        rs1_data_i = a;
        rs2_data_i = b;
        pc_adder_i = rand_word() & ~32'd3;
        imm_i = rand_word();
        client_int_addr_i = rand_word() & ~32'd3;
        {client_hold_flag_i, client_int_assert_i, access_mem_hold_i,
         pr_access_mem_flag_i, alu_busy_i, bus_wait_i} = tab_hold[idx];
        branch_i = tab_br[idx];
        jump_i = tab_jp[idx];
    endtask

    // ------------------------------------------------------------------
    // reference model from the priority rules
    // ------------------------------------------------------------------
    task automatic predict(int idx);
        logic [5:0] h;
        logic taken, seq, lt_s, lt_u, up;
        logic [3:0] nv;
        cpu_word_t target;
        flow_t c;
        h = tab_hold[idx];
        seq = 1'b0;
        target = '0;
        lt_s = $signed(rs1_data_i) < $signed(rs2_data_i);
        lt_u = rs1_data_i < rs2_data_i;
        case (tab_br[idx])
            BRANCH_BEQ:  taken = (rs1_data_i == rs2_data_i);
            BRANCH_BNE:  taken = (rs1_data_i != rs2_data_i);
            BRANCH_BLT:  taken = lt_s;
            BRANCH_BGE:  taken = !lt_s;
            BRANCH_BLTU: taken = lt_u;
            BRANCH_BGEU: taken = !lt_u;
            default:     taken = 1'b0;
        endcase
        if (h[5] && h[4]) begin
            exp_codes = pack5(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, FLOW_REFRESH, FLOW_REFRESH);
            target = client_int_addr_i;
        end else if (h[5]) exp_codes = {5{FLOW_STOP}};
        else if (h[3]) exp_codes = pack5(FLOW_STOP, FLOW_STOP, FLOW_STOP, FLOW_STOP, FLOW_REFRESH);
        else if (h[2]) exp_codes = pack5(FLOW_STOP, FLOW_STOP, FLOW_REFRESH, FLOW_WORK, FLOW_WORK);
        else if (h[1]) exp_codes = pack5(FLOW_STOP, FLOW_STOP, FLOW_STOP, FLOW_REFRESH, FLOW_WORK);
        else if (h[0]) exp_codes = pack5(FLOW_STOP, FLOW_REFRESH, FLOW_WORK, FLOW_WORK, FLOW_WORK);
        else if (tab_br[idx] != BRANCH_NONE && taken) begin
            exp_codes = pack5(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, FLOW_WORK, FLOW_WORK);
            target = pc_adder_i + imm_i;
        end else if (tab_br[idx] == BRANCH_NONE && tab_jp[idx] != JUMP_NONE) begin
            exp_codes = pack5(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, FLOW_WORK, FLOW_WORK);
            if (tab_jp[idx] == JUMP_JAL) target = pc_adder_i + imm_i;
            else if (tab_jp[idx] == JUMP_JALR) target = rs1_data_i + imm_i;
            else target = pc_adder_i + 32'd4;
        end else begin
            exp_codes = '0;   // all work with sequential fetch
            seq = 1'b1;
        end
        if (exp_codes[9:8] != FLOW_STOP) m_pc = seq ? m_pc + 32'd4 : target;
        for (int k = 0; k < 4; k++) begin
            c = exp_codes[(3-k)*2 +: 2];
            up = (k == 0) ? (exp_codes[9:8] == FLOW_WORK) : m_valid[k-1];
            nv[k] = (c == FLOW_WORK) ? up : (c == FLOW_REFRESH) ? 1'b0 : m_valid[k];
        end
        m_valid = nv;
    endtask

    initial begin
        {bus_wait_i, alu_busy_i, access_mem_hold_i, pr_access_mem_flag_i} = '0;
        {client_hold_flag_i, client_int_assert_i} = '0;
        {branch_i, jump_i} = '0;
        {pc_adder_i, imm_i, rs1_data_i, rs2_data_i, client_int_addr_i} = '0;
        reset_i = 1'b1;
        for (int n = 0; n < 5; n++) add_row("idle_fill", 6'b0, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("beq_taken", 6'b0, OP_EQ, BRANCH_BEQ, JUMP_NONE);
        add_row("beq_not", 6'b0, OP_MORE, BRANCH_BEQ, JUMP_NONE);
        add_row("bne_taken", 6'b0, OP_LESS, BRANCH_BNE, JUMP_NONE);
        add_row("bne_not", 6'b0, OP_EQ, BRANCH_BNE, JUMP_NONE);
        add_row("blt_taken", 6'b0, OP_LESS, BRANCH_BLT, JUMP_NONE);
        add_row("blt_not", 6'b0, OP_MORE, BRANCH_BLT, JUMP_NONE);
        add_row("bge_taken", 6'b0, OP_EQ, BRANCH_BGE, JUMP_NONE);
        add_row("bge_not", 6'b0, OP_LESS, BRANCH_BGE, JUMP_NONE);
        add_row("bltu_taken", 6'b0, OP_LESS, BRANCH_BLTU, JUMP_NONE);
        add_row("bltu_not", 6'b0, OP_EQ, BRANCH_BLTU, JUMP_NONE);
        add_row("bgeu_taken", 6'b0, OP_MORE, BRANCH_BGEU, JUMP_NONE);
        add_row("bgeu_not", 6'b0, OP_LESS, BRANCH_BGEU, JUMP_NONE);
        add_row("blt_rand", 6'b0, OP_RAND, BRANCH_BLT, JUMP_NONE);
        add_row("bltu_rand", 6'b0, OP_RAND, BRANCH_BLTU, JUMP_NONE);
        add_row("jal", 6'b0, OP_RAND, BRANCH_NONE, JUMP_JAL);
        add_row("jalr", 6'b0, OP_RAND, BRANCH_NONE, JUMP_JALR);
        add_row("fence", 6'b0, OP_RAND, BRANCH_NONE, JUMP_FENCE);
        for (int n = 0; n < 3; n++) add_row("idle_refill", 6'b0, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("bus_wait", 6'b000001, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("alu_busy", 6'b000010, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("pr_access", 6'b000100, OP_RAND, BRANCH_NONE, JUMP_NONE);
        for (int n = 0; n < 4; n++) add_row("idle_refill", 6'b0, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("access_hold", 6'b001000, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("idle_refill", 6'b0, OP_RAND, BRANCH_NONE, JUMP_NONE);
        add_row("client_freeze", 6'b101111, OP_EQ, BRANCH_BEQ, JUMP_NONE);
        add_row("client_int", 6'b110000, OP_RAND, BRANCH_NONE, JUMP_JAL);
        add_row("idle_after_int", 6'b0, OP_RAND, BRANCH_NONE, JUMP_NONE);

        // reset must load the pc well within the reset window
        cyc = 0;
        while (pc_o !== TB_RESET_PC && cyc < 16) begin
            @(negedge clk_i);
            cyc++;
        end
        if (pc_o !== TB_RESET_PC) begin
            $display("timeout: pc never took the reset address");
            $display("TESTBENCH FAILED");
            $finish;
        end
        while (cyc < 16) begin
            @(negedge clk_i);
            cyc++;
        end
        reset_i = 1'b0;
        m_pc = TB_RESET_PC;
        m_valid = '0;
        assert (pc_o === m_pc && {valid_wb_o, valid_as_o, valid_ex_o, valid_de_o} === 4'b0) else begin
            $display("FAILED reset: expected pc %h valid 0000, actual pc %h valid %b", m_pc, pc_o,
                     {valid_wb_o, valid_as_o, valid_ex_o, valid_de_o});
            pc_errs++;
        end

        // ------------------------------------------------------------------
        // apply the table one row per cycle
        // ------------------------------------------------------------------
        for (int i = 0; i < tab_name.size(); i++) begin
            drive_row(i);
            #1;
            predict(i);
            assert ({flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o} === exp_codes) else begin
                $display("FAILED %s: flow codes expected %h actual %h", tab_name[i], exp_codes,
                         {flow_pc_o, flow_de_o, flow_ex_o, flow_as_o, flow_wb_o});
                flow_errs++;
            end
            @(negedge clk_i);
            assert (pc_o === m_pc) else begin
                $display("FAILED %s: pc expected %h actual %h", tab_name[i], m_pc, pc_o);
                pc_errs++;
            end
            assert ({valid_wb_o, valid_as_o, valid_ex_o, valid_de_o} === m_valid) else begin
                $display("FAILED %s: valid wb..de expected %b actual %b", tab_name[i], m_valid,
                         {valid_wb_o, valid_as_o, valid_ex_o, valid_de_o});
                valid_errs++;
            end
        end

        $display("errors: flow %0d, pc %0d, valid %0d", flow_errs, pc_errs, valid_errs);
        if (flow_errs + pc_errs + valid_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
flow_pkg.sv
branch_cmp.sv
flow_ctrl.sv
pc_reg.sv
stage_valid.sv
flow_top.sv
flow_tb_sva.sv
flow_tb.sv
